/* Makefile */
SIM = obj_dir/Vfb_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module fb_tb -f list.f -o Vfb_tb

run: compile
	./$(SIM) | tee /dev/stderr | grep -q '^TEST OK$$'

clean:
	rm -rf obj_dir

/* bench/fb_checker.sv */
`timescale 1ns/1ps
module fb_checker (
    input logic                          i_wr_clk,
    input logic                          i_rd_clk,
    input logic                          i_reset,
    input logic                          i_wr_fire,
    input logic                          i_rd_valid,
    input logic [fb_pkg::FIFO_PTR_W-1:0] i_wr_bin,
    input logic [fb_pkg::FIFO_PTR_W-1:0] i_rd_bin,
    input logic [fb_pkg::FIFO_PTR_W-1:0] i_rd_gray_sync,
    input logic [fb_pkg::FIFO_PTR_W-1:0] i_wr_gray_sync
);
    logic [fb_pkg::FIFO_PTR_W-1:0] fill;    // true occupancy from both live pointers

    assign fill = i_wr_bin - i_rd_bin;

    // a write on a full fifo would overwrite the oldest entry
    assert property (@(posedge i_wr_clk) disable iff (i_reset)
        !(i_wr_fire && int'(fill) == fb_pkg::FIFO_DEPTH))
        else $error("fifo write accepted while full");

    assert property (@(posedge i_rd_clk) disable iff (i_reset)
        !(i_rd_valid && fill == '0))
        else $error("fifo receiver valid while empty");

    // gray pointers step one bit at a time across the crossing
    assert property (@(posedge i_wr_clk) disable iff (i_reset)
        $countones(i_rd_gray_sync ^ $past(i_rd_gray_sync)) <= 1)
        else $error("synchronised read pointer jumped more than one bit");

    assert property (@(posedge i_rd_clk) disable iff (i_reset)
        $countones(i_wr_gray_sync ^ $past(i_wr_gray_sync)) <= 1)
        else $error("synchronised write pointer jumped more than one bit");

endmodule

/* bench/fb_monitor.sv */
`timescale 1ns/1ps
module fb_monitor (
    input  logic                     i_clk_pixel,
    input  logic                     i_reset,
    input  logic                     i_active_draw,
    input  logic [fb_pkg::H_W-1:0]   i_h_count,
    input  logic [fb_pkg::V_W-1:0]   i_v_count,
    input  logic [fb_pkg::PIX_W-1:0] i_pixel,
    input  logic                     i_overflow,
    input  logic [2:0]               i_phase,
    output logic                     o_aligned,
    output int                       o_checks,
    output int                       o_errors
);
    int         test_checks;    // per test, cleared on phase change
    int         test_errors;
    logic [2:0] last_phase;
    logic [fb_pkg::PIX_W-1:0] exp_pix;

    // every raster position gets its own value, none equal to the blank colour
    function automatic logic [fb_pkg::PIX_W-1:0] expected_pixel(input int h, input int v);
        return 16'hA500 ^ 16'(v * fb_pkg::FRAME_W + h);
    endfunction

    function automatic string test_name(input logic [2:0] phase);
        case (phase)
            3'd0:    return "blank before first frame";
            3'd1:    return "raster realignment";
            3'd2:    return "frame round trip";
            default: return "back-pressure tolerance";
        endcase
    endfunction

    always @(posedge i_clk_pixel) begin
        if (i_reset) begin
            o_aligned   = 1'b0;
            o_checks    = 0;
            o_errors    = 0;
            test_checks = 0;
            test_errors = 0;
            last_phase  = 3'd0;
        end else begin
            if (i_phase != last_phase) begin
                if (last_phase == 3'd3) begin          // overflow judged over the whole test
                    test_checks++;
                    if (i_overflow) begin
                        test_errors++;
                        $display("** Error at %0t: camera overflow expected 0 observed 1",
                                 $time);
                    end
                end
                if (test_checks == 0) begin
                    test_errors++;
                    $display("test %0d compared no pixels at all", last_phase);
                end
                $display("test %0d %s: %0d checks, %0d errors", last_phase,
                         test_name(last_phase), test_checks, test_errors);
                o_checks    += test_checks;
                o_errors    += test_errors;
                test_checks = 0;
                test_errors = 0;
                last_phase  = i_phase;
            end
            if (i_active_draw && i_phase <= 3'd3) begin
                if (i_phase == 3'd0) begin
                    exp_pix = fb_pkg::BLANK_COLOR;
                end else begin
                    exp_pix = expected_pixel(int'(i_h_count), int'(i_v_count));
                end
                if (i_phase == 3'd0 || o_aligned) begin
                    test_checks++;
                    if (i_pixel !== exp_pix) begin
                        test_errors++;
                        $display("** Error at %0t: pixel (%0d,%0d) expected %h observed %h",
                                 $time, i_h_count, i_v_count, exp_pix, i_pixel);
                    end
                end else if (int'(i_h_count) == fb_pkg::FRAME_W - 1
                             && int'(i_v_count) == fb_pkg::FRAME_H - 1
                             && i_pixel == exp_pix) begin
                    o_aligned = 1'b1;                   // last pixel left at the corner
                end
            end
        end
    end

endmodule

/* bench/fb_tb.sv */
`timescale 1ns/1ps
module fb_tb;

    localparam int SHORT_H_BLANK = 16;
    localparam int LONG_H_BLANK  = 80;     // stretches the line, fifo sits at almost-full
    localparam int V_BLANK       = 2;
    localparam int V_TOTAL       = fb_pkg::FRAME_H + V_BLANK;
    localparam int SHORT_FRAME   = (fb_pkg::FRAME_W + SHORT_H_BLANK) * V_TOTAL;
    localparam int LONG_FRAME    = (fb_pkg::FRAME_W + LONG_H_BLANK) * V_TOTAL;
    localparam int TIMEOUT       = 4 * (7 * SHORT_FRAME + 3 * LONG_FRAME);

    logic                     clk_camera = 1'b0;
    logic                     clk_controller = 1'b0;
    logic                     clk_pixel = 1'b0;
    logic                     reset = 1'b1;
    logic                     camera_valid = 1'b0;
    logic [fb_pkg::PIX_W-1:0] camera_pixel = '0;
    logic [fb_pkg::H_W-1:0]   camera_h = '0;
    logic [fb_pkg::V_W-1:0]   camera_v = '0;
    logic                     active_draw = 1'b0;
    logic [fb_pkg::H_W-1:0]   h_count = '0;
    logic [fb_pkg::V_W-1:0]   v_count = '0;
    logic [fb_pkg::PIX_W-1:0] pixel_out;
    logic                     camera_overflow;
    logic [2:0]               phase = 3'd0;
    logic                     aligned;
    logic                     long_blank = 1'b0;
    int                       checks, errors;
    int                       cam_frames = 0;
    int                       disp_frames = 0;
    int                       cycles = 0;
    int                       base;

    bind async_chunk_fifo fb_checker u_fifo_checker (
        .i_wr_clk(i_wr_clk), .i_rd_clk(i_rd_clk), .i_reset(i_reset),
        .i_wr_fire(wr_fire), .i_rd_valid(o_rd_valid),
        .i_wr_bin(wr_bin), .i_rd_bin(rd_bin),
        .i_rd_gray_sync(rd_gray_sync), .i_wr_gray_sync(wr_gray_sync)
    );

    frame_buffer_top DUT (
        .i_clk_camera(clk_camera), .i_clk_controller(clk_controller),
        .i_clk_pixel(clk_pixel), .i_reset(reset),
        .i_camera_valid(camera_valid), .i_camera_pixel(camera_pixel),
        .i_camera_h_count(camera_h), .i_camera_v_count(camera_v),
        .i_active_draw(active_draw), .i_h_count(h_count), .i_v_count(v_count),
        .o_pixel(pixel_out), .o_camera_overflow(camera_overflow)
    );

    fb_monitor MON (
        .i_clk_pixel(clk_pixel), .i_reset(reset), .i_active_draw(active_draw),
        .i_h_count(h_count), .i_v_count(v_count), .i_pixel(pixel_out),
        .i_overflow(camera_overflow), .i_phase(phase),
        .o_aligned(aligned), .o_checks(checks), .o_errors(errors)
    );

    // camera stimulus, one value per raster position
    function automatic logic [fb_pkg::PIX_W-1:0] camera_value(input int h, input int v);
        return 16'hA500 ^ 16'(v * fb_pkg::FRAME_W + h);
    endfunction

    initial forever #5 clk_camera = ~clk_camera;
    initial forever #6 clk_controller = ~clk_controller;
    initial begin
        #3;
        forever #5 clk_pixel = ~clk_pixel;
    end

    initial begin
        repeat (3) @(posedge clk_controller);
        #1 reset = 1'b0;
    end

    initial begin                                      // camera frames, gapped valid
        void'($urandom(38));
        wait (!reset);
        @(posedge clk_camera);
        #1;
        forever begin
            for (int v = 0; v < fb_pkg::FRAME_H; v++) begin
                for (int h = 0; h < fb_pkg::FRAME_W; h++) begin
                    while ($urandom % 4 == 0) begin
                        camera_valid = 1'b0;
                        @(posedge clk_camera);
                        #1;
                    end
                    camera_valid = 1'b1;
                    camera_pixel = camera_value(h, v);
                    camera_h     = fb_pkg::H_W'(h);
                    camera_v     = fb_pkg::V_W'(v);
                    @(posedge clk_camera);
                    #1;
                end
            end
            camera_valid = 1'b0;
            cam_frames++;
        end
    end

    initial begin                                      // display raster, starts mid-frame
        int h;
        int v;
        int h_total;
        h = 20;
        v = 3;
        wait (!reset);
        @(posedge clk_pixel);
        #1;
        forever begin
            h_total     = fb_pkg::FRAME_W + (long_blank ? LONG_H_BLANK : SHORT_H_BLANK);
            h_count     = fb_pkg::H_W'(h);
            v_count     = fb_pkg::V_W'(v);
            active_draw = h < fb_pkg::FRAME_W && v < fb_pkg::FRAME_H;
            @(posedge clk_pixel);
            #1;
            if (h >= h_total - 1) begin
                h = 0;
                if (v == V_TOTAL - 1) begin
                    v = 0;
                    disp_frames++;
                end else begin
                    v++;
                end
            end else begin
                h++;
            end
        end
    end

    always @(posedge clk_pixel) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("run timed out after %0d pixel clocks in test %0d", cycles, phase);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        wait (!reset);
        wait (cam_frames >= 1);                        // first frame now on its way to memory
        phase = 3'd1;
        wait (aligned);
        base = disp_frames;
        wait (disp_frames == base + 2);
        phase = 3'd2;
        base  = disp_frames;
        wait (disp_frames == base + 2);
        long_blank = 1'b1;
        phase      = 3'd3;
        base       = disp_frames;
        wait (disp_frames == base + 3);
        phase = 3'd4;
        repeat (2) @(posedge clk_pixel);
        $display("tests 4, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
src/fb_pkg.sv
src/pixel_stacker.sv
src/async_chunk_fifo.sv
src/frame_traffic_gen.sv
src/burst_memory.sv
src/pixel_unstacker.sv
src/frame_buffer_top.sv
bench/fb_checker.sv
bench/fb_monitor.sv
bench/fb_tb.sv

/* src/async_chunk_fifo.sv */
`timescale 1ns/1ps
module async_chunk_fifo (
    input  logic                       i_reset,
    input  logic                       i_wr_clk,
    input  logic                       i_wr_valid,
    input  logic [fb_pkg::CHUNK_W-1:0] i_wr_data,
    input  logic                       i_wr_last,
    output logic                       o_wr_ready,
    output logic                       o_wr_almost_full,
    input  logic                       i_rd_clk,
    input  logic                       i_rd_ready,
    output logic                       o_rd_valid,
    output logic [fb_pkg::CHUNK_W-1:0] o_rd_data,
    output logic                       o_rd_last
);
    logic [fb_pkg::CHUNK_W:0]    mem [fb_pkg::FIFO_DEPTH];   // {last, chunk}

    logic [fb_pkg::FIFO_PTR_W-1:0] wr_bin, wr_gray, wr_bin_next;
    logic [fb_pkg::FIFO_PTR_W-1:0] rd_gray_meta, rd_gray_sync;  // read ptr in write domain
    logic [fb_pkg::FIFO_PTR_W-1:0] wr_count;
    logic                          full;
    logic                          wr_fire;

    logic [fb_pkg::FIFO_PTR_W-1:0] rd_bin, rd_gray, rd_bin_next;
    logic [fb_pkg::FIFO_PTR_W-1:0] wr_gray_meta, wr_gray_sync;  // write ptr in read domain
    logic                          empty;
    logic                          rd_fire;

    function automatic logic [fb_pkg::FIFO_PTR_W-1:0] gray_to_bin(
        input logic [fb_pkg::FIFO_PTR_W-1:0] g
    );
        logic [fb_pkg::FIFO_PTR_W-1:0] b;
        for (int i = 0; i < fb_pkg::FIFO_PTR_W; i++) begin
            b[i] = ^(g >> i);                           // xor of all higher gray bits
        end
        return b;
    endfunction

    // sender side
    assign full = wr_gray == {~rd_gray_sync[fb_pkg::FIFO_PTR_W-1:fb_pkg::FIFO_PTR_W-2],
                              rd_gray_sync[fb_pkg::FIFO_PTR_W-3:0]};
    assign o_wr_ready  = !full;
    assign wr_fire     = i_wr_valid && !full;
    assign wr_bin_next = wr_bin + 1'b1;
    assign wr_count    = wr_bin - gray_to_bin(rd_gray_sync);  // stale read ptr overestimates
    assign o_wr_almost_full = int'(wr_count) >= fb_pkg::FIFO_AF_LEVEL;

    always_ff @(posedge i_wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[fb_pkg::FIFO_PTR_W-2:0]] <= {i_wr_last, i_wr_data};
        end
    end

    always_ff @(posedge i_wr_clk) begin
        if (i_reset) begin
            wr_bin       <= '0;
            wr_gray      <= '0;
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            rd_gray_meta <= rd_gray;                    // two-flop synchroniser
            rd_gray_sync <= rd_gray_meta;
            if (wr_fire) begin
                wr_bin  <= wr_bin_next;
                wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            end
        end
    end

    // receiver side
    assign empty       = rd_gray == wr_gray_sync;
    assign o_rd_valid  = !empty;
    assign rd_fire     = i_rd_ready && !empty;
    assign rd_bin_next = rd_bin + 1'b1;
    assign {o_rd_last, o_rd_data} = mem[rd_bin[fb_pkg::FIFO_PTR_W-2:0]];  // first word fall-through

    always_ff @(posedge i_rd_clk) begin
        if (i_reset) begin
            rd_bin       <= '0;
            rd_gray      <= '0;
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
            if (rd_fire) begin
                rd_bin  <= rd_bin_next;
                rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
            end
        end
    end

endmodule

/* src/burst_memory.sv */
`timescale 1ns/1ps
module burst_memory (
    input  logic                       i_clk_controller,
    input  logic                       i_reset,
    input  logic                       i_stb,
    input  logic                       i_we,
    input  logic [fb_pkg::ADDR_W-1:0]  i_addr,
    input  logic [fb_pkg::CHUNK_W-1:0] i_wdata,
    output logic                       o_busy,
    output logic                       o_ack,
    output logic [fb_pkg::CHUNK_W-1:0] o_rdata
);
    logic [fb_pkg::CHUNK_W-1:0] mem [fb_pkg::CHUNKS_PER_FRAME];
    logic [fb_pkg::CHUNK_W-1:0] data_pipe [fb_pkg::MEM_LATENCY];   // read data in flight
    logic [fb_pkg::MEM_LATENCY-1:0] ack_pipe;                       // one bit per accepted request
    logic [$clog2(fb_pkg::REFRESH_PERIOD)-1:0] refresh_cnt;
    logic accept;

    // refresh window sits at the end of each period
    assign o_busy  = int'(refresh_cnt) >= fb_pkg::REFRESH_PERIOD - fb_pkg::REFRESH_CYCLES;
    assign accept  = i_stb && !o_busy;
    assign o_ack   = ack_pipe[fb_pkg::MEM_LATENCY-1];
    assign o_rdata = data_pipe[fb_pkg::MEM_LATENCY-1];

    always_ff @(posedge i_clk_controller) begin
        if (accept && i_we) begin
            mem[i_addr] <= i_wdata;
        end
        data_pipe[0] <= mem[i_addr];                     // sampled at acceptance
        for (int i = 1; i < fb_pkg::MEM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge i_clk_controller) begin
        if (i_reset) begin
            ack_pipe    <= '0;
            refresh_cnt <= '0;
        end else begin
            ack_pipe <= {ack_pipe[fb_pkg::MEM_LATENCY-2:0], accept};
            if (int'(refresh_cnt) == fb_pkg::REFRESH_PERIOD - 1) begin
                refresh_cnt <= '0;
            end else begin
                refresh_cnt <= refresh_cnt + 1'b1;        // free running
            end
        end
    end

endmodule

/* src/fb_pkg.sv */
package fb_pkg;

    localparam int FRAME_W             = 64;    // active pixels per line, multiple of 8
    localparam int FRAME_H             = 8;     // lines per frame, small for simulation
    localparam int PIX_W               = 16;    // rgb565 pixel
    localparam int PIX_PER_CHUNK       = 8;
    localparam int CHUNK_W             = 128;   // one memory word
    localparam int CHUNKS_PER_FRAME    = FRAME_W * FRAME_H / PIX_PER_CHUNK;
    localparam int ADDR_W              = 6;     // chunk address into the frame region
    localparam int H_W                 = 11;    // raster h counter
    localparam int V_W                 = 10;    // raster v counter

    localparam int FIFO_DEPTH          = 16;    // chunks per clock-crossing fifo
    localparam int FIFO_PTR_W          = 5;     // index plus wrap bit
    localparam int MAX_READS_IN_FLIGHT = 6;
    localparam int FIFO_AF_LEVEL       = FIFO_DEPTH - MAX_READS_IN_FLIGHT;

    localparam int MEM_LATENCY         = 4;     // accepted strobe to ack
    localparam int REFRESH_PERIOD      = 64;
    localparam int REFRESH_CYCLES      = 4;     // busy cycles per refresh period

    localparam logic [PIX_W-1:0] BLANK_COLOR = 16'h2277;

    // a chunk is one memory word or eight pixels, pixel 0 in the low bits
    typedef union packed {
        logic [CHUNK_W-1:0]                  word;
        logic [PIX_PER_CHUNK-1:0][PIX_W-1:0] pix;
    } chunk_u;

endpackage

/* src/frame_buffer_top.sv */
`timescale 1ns/1ps
module frame_buffer_top (
    input  logic                     i_clk_camera,
    input  logic                     i_clk_controller,
    input  logic                     i_clk_pixel,
    input  logic                     i_reset,
    input  logic                     i_camera_valid,
    input  logic [fb_pkg::PIX_W-1:0] i_camera_pixel,
    input  logic [fb_pkg::H_W-1:0]   i_camera_h_count,
    input  logic [fb_pkg::V_W-1:0]   i_camera_v_count,
    input  logic                     i_active_draw,
    input  logic [fb_pkg::H_W-1:0]   i_h_count,
    input  logic [fb_pkg::V_W-1:0]   i_v_count,
    output logic [fb_pkg::PIX_W-1:0] o_pixel,
    output logic                     o_camera_overflow
);
    logic                       camera_last;
    fb_pkg::chunk_u             cam_chunk;          // camera domain
    logic                       cam_valid, cam_ready, cam_last;
    fb_pkg::chunk_u             wr_chunk;           // controller domain, toward memory
    logic                       wr_valid, wr_ready, wr_last;
    fb_pkg::chunk_u             rd_chunk;           // controller domain, from memory
    logic                       rd_valid, rd_last, rd_almost_full;
    logic                       mem_stb, mem_we, mem_busy, mem_ack;
    logic [fb_pkg::ADDR_W-1:0]  mem_addr;
    logic [fb_pkg::CHUNK_W-1:0] mem_wdata, mem_rdata;
    fb_pkg::chunk_u             disp_chunk;         // pixel domain
    logic                       disp_valid, disp_ready, disp_last;
    logic [fb_pkg::PIX_W-1:0]   pix;
    logic                       pix_valid, pix_ready, pix_last, final_pos;

    assign camera_last = int'(i_camera_h_count) == fb_pkg::FRAME_W - 1
                         && int'(i_camera_v_count) == fb_pkg::FRAME_H - 1;
    assign final_pos   = int'(i_h_count) == fb_pkg::FRAME_W - 1
                         && int'(i_v_count) == fb_pkg::FRAME_H - 1;
    // frame's last pixel waits for the raster corner, realigning output to the frame
    assign pix_ready = i_active_draw && (!pix_last || final_pos);
    assign o_pixel   = pix_valid ? pix : fb_pkg::BLANK_COLOR;

    pixel_stacker u_stacker (
        .i_clk_camera (i_clk_camera),   .i_reset       (i_reset),
        .i_pixel_valid(i_camera_valid), .i_pixel       (i_camera_pixel),
        .i_pixel_last (camera_last),    .o_chunk_valid (cam_valid),
        .o_chunk      (cam_chunk),      .o_chunk_last  (cam_last),
        .o_overflow   (o_camera_overflow), .i_chunk_ready(cam_ready)
    );

    async_chunk_fifo u_write_fifo (     // camera to controller
        .i_reset   (i_reset),          .i_wr_clk        (i_clk_camera),
        .i_wr_valid(cam_valid),        .i_wr_data       (cam_chunk),
        .i_wr_last (cam_last),         .o_wr_ready      (cam_ready),
        .o_wr_almost_full(),           .i_rd_clk        (i_clk_controller),
        .i_rd_ready(wr_ready),         .o_rd_valid      (wr_valid),
        .o_rd_data (wr_chunk),         .o_rd_last       (wr_last)
    );

    frame_traffic_gen u_traffic (
        .i_clk_controller(i_clk_controller), .i_reset    (i_reset),
        .i_wr_valid (wr_valid),        .i_wr_data       (wr_chunk),
        .i_wr_last  (wr_last),         .o_wr_ready      (wr_ready),
        .o_rd_valid (rd_valid),        .o_rd_data       (rd_chunk),
        .o_rd_last  (rd_last),         .i_rd_almost_full(rd_almost_full),
        .o_mem_stb  (mem_stb),         .o_mem_we        (mem_we),
        .o_mem_addr (mem_addr),        .o_mem_wdata     (mem_wdata),
        .i_mem_busy (mem_busy),        .i_mem_ack       (mem_ack),
        .i_mem_rdata(mem_rdata)
    );

    burst_memory u_memory (
        .i_clk_controller(i_clk_controller), .i_reset(i_reset),
        .i_stb  (mem_stb),             .i_we   (mem_we),
        .i_addr (mem_addr),            .i_wdata(mem_wdata),
        .o_busy (mem_busy),            .o_ack  (mem_ack),
        .o_rdata(mem_rdata)
    );

    async_chunk_fifo u_display_fifo (   // controller to pixel, never pushed while full
        .i_reset   (i_reset),          .i_wr_clk        (i_clk_controller),
        .i_wr_valid(rd_valid),         .i_wr_data       (rd_chunk),
        .i_wr_last (rd_last),          .o_wr_ready      (),
        .o_wr_almost_full(rd_almost_full), .i_rd_clk    (i_clk_pixel),
        .i_rd_ready(disp_ready),       .o_rd_valid      (disp_valid),
        .o_rd_data (disp_chunk),       .o_rd_last       (disp_last)
    );

    pixel_unstacker u_unstacker (
        .i_clk_pixel  (i_clk_pixel),   .i_reset      (i_reset),
        .i_chunk_valid(disp_valid),    .i_chunk      (disp_chunk),
        .i_chunk_last (disp_last),     .o_chunk_ready(disp_ready),
        .o_pixel_valid(pix_valid),     .o_pixel      (pix),
        .o_pixel_last (pix_last),      .i_pixel_ready(pix_ready)
    );

endmodule

/* src/frame_traffic_gen.sv */
`timescale 1ns/1ps
module frame_traffic_gen (
    input  logic                       i_clk_controller,
    input  logic                       i_reset,
    input  logic                       i_wr_valid,
    input  fb_pkg::chunk_u             i_wr_data,
    input  logic                       i_wr_last,
    output logic                       o_wr_ready,
    output logic                       o_rd_valid,
    output fb_pkg::chunk_u             o_rd_data,
    output logic                       o_rd_last,
    input  logic                       i_rd_almost_full,
    output logic                       o_mem_stb,
    output logic                       o_mem_we,
    output logic [fb_pkg::ADDR_W-1:0]  o_mem_addr,
    output logic [fb_pkg::CHUNK_W-1:0] o_mem_wdata,
    input  logic                       i_mem_busy,
    input  logic                       i_mem_ack,
    input  logic [fb_pkg::CHUNK_W-1:0] i_mem_rdata
);
    logic [fb_pkg::ADDR_W-1:0] wr_addr;         // next chunk slot for camera data
    logic [fb_pkg::ADDR_W-1:0] rd_addr;         // next chunk slot for display
    logic                      rd_enable;       // first frame fully in memory
    logic                      last_was_write;  // alternation between contending types
    logic [2:0]                rd_inflight;     // accepted reads not yet acked
    logic [3:0]                rd_outstanding;
    logic [1:0]                req_q [2*fb_pkg::MEM_LATENCY];   // {is_read, is_last}
    logic [$clog2(2*fb_pkg::MEM_LATENCY)-1:0] q_wr, q_rd;
    logic accepted, slot_free, wr_pending, rd_pending, issue_wr, issue_rd;
    logic ack_read, ack_last;

    assign accepted    = o_mem_stb && !i_mem_busy;
    assign slot_free   = !o_mem_stb || !i_mem_busy;      // strobe register can take a new request
    assign o_wr_ready  = accepted && o_mem_we;           // pop as memory takes the chunk
    assign o_mem_wdata = i_wr_data.word;                 // fifo head holds until popped
    assign wr_pending  = i_wr_valid && !o_wr_ready;      // popped head is stale this cycle

    assign rd_outstanding = {1'b0, rd_inflight} + {3'b000, o_mem_stb && !o_mem_we};
    assign rd_pending = rd_enable && !i_rd_almost_full
                        && int'(rd_outstanding) < fb_pkg::MAX_READS_IN_FLIGHT;

    // writes win unless a read lost the last contest
    assign issue_wr = slot_free && wr_pending && !(rd_pending && last_was_write);
    assign issue_rd = slot_free && rd_pending && !issue_wr;

    // responses come back in order, head of queue says what this ack is
    assign ack_read       = req_q[q_rd][1];
    assign ack_last       = req_q[q_rd][0];
    assign o_rd_valid     = i_mem_ack && ack_read;       // display fifo always has room
    assign o_rd_data.word = i_mem_rdata;
    assign o_rd_last      = ack_last;

    always_ff @(posedge i_clk_controller) begin
        if (issue_wr) begin
            o_mem_we   <= 1'b1;
            o_mem_addr <= wr_addr;
        end else if (issue_rd) begin
            o_mem_we   <= 1'b0;
            o_mem_addr <= rd_addr;
        end
        if (accepted) begin
            req_q[q_wr] <= {!o_mem_we, o_mem_we ? i_wr_last
                            : int'(o_mem_addr) == fb_pkg::CHUNKS_PER_FRAME - 1};
        end
    end

    always_ff @(posedge i_clk_controller) begin
        if (i_reset) begin
            o_mem_stb      <= 1'b0;
            wr_addr        <= '0;
            rd_addr        <= '0;
            rd_enable      <= 1'b0;
            last_was_write <= 1'b0;
            rd_inflight    <= '0;
            q_wr           <= '0;
            q_rd           <= '0;
        end else begin
            if (slot_free) begin
                o_mem_stb <= issue_wr || issue_rd;
            end
            if (issue_wr) begin                          // frame end realigns the write slot
                last_was_write <= 1'b1;
                if (i_wr_last || int'(wr_addr) == fb_pkg::CHUNKS_PER_FRAME - 1) begin
                    wr_addr <= '0;
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
            if (issue_rd) begin
                last_was_write <= 1'b0;
                if (int'(rd_addr) == fb_pkg::CHUNKS_PER_FRAME - 1) begin
                    rd_addr <= '0;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
            if (accepted) begin
                q_wr <= q_wr + 1'b1;
            end
            if (i_mem_ack) begin
                q_rd <= q_rd + 1'b1;
                if (!ack_read && ack_last) begin
                    rd_enable <= 1'b1;                   // whole frame now readable
                end
            end
            case ({accepted && !o_mem_we, o_rd_valid})
                2'b10:   rd_inflight <= rd_inflight + 1'b1;
                2'b01:   rd_inflight <= rd_inflight - 1'b1;
                default: rd_inflight <= rd_inflight;
            endcase
        end
    end

endmodule

/* src/pixel_stacker.sv */
`timescale 1ns/1ps
module pixel_stacker (
    input  logic                     i_clk_camera,
    input  logic                     i_reset,
    input  logic                     i_pixel_valid,
    input  logic [fb_pkg::PIX_W-1:0] i_pixel,
    input  logic                     i_pixel_last,
    output logic                     o_chunk_valid,
    output fb_pkg::chunk_u           o_chunk,
    output logic                     o_chunk_last,
    output logic                     o_overflow,
    input  logic                     i_chunk_ready
);
    fb_pkg::chunk_u fill;           // chunk being assembled
    fb_pkg::chunk_u fill_next;      // fill with the current pixel dropped in
    logic [2:0]     pix_idx;        // next slot to fill
    logic           last_seen;      // frame end already landed in this chunk
    logic           stall;
    logic           take;

    assign stall = o_chunk_valid && !i_chunk_ready;    // previous chunk not yet taken
    assign take  = i_pixel_valid && !stall;

    always_comb begin
        fill_next              = fill;
        fill_next.pix[pix_idx] = i_pixel;
    end

    always_ff @(posedge i_clk_camera) begin
        if (take) begin
            fill <= fill_next;
        end
        if (take && &pix_idx) begin                     // eighth pixel closes the chunk
            o_chunk      <= fill_next;
            o_chunk_last <= last_seen || i_pixel_last;
        end
    end

    always_ff @(posedge i_clk_camera) begin
        if (i_reset) begin
            pix_idx       <= '0;
            last_seen     <= 1'b0;
            o_chunk_valid <= 1'b0;
            o_overflow    <= 1'b0;
        end else begin
            if (take) begin
                pix_idx   <= pix_idx + 1'b1;            // wraps after slot 7
                last_seen <= !(&pix_idx) && (last_seen || i_pixel_last);
            end
            if (take && &pix_idx) begin
                o_chunk_valid <= 1'b1;
            end else if (i_chunk_ready) begin
                o_chunk_valid <= 1'b0;
            end
            if (i_pixel_valid && stall) begin
                o_overflow <= 1'b1;                     // sticky, pixel is lost
            end
        end
    end

endmodule

/* src/pixel_unstacker.sv */
`timescale 1ns/1ps
module pixel_unstacker (
    input  logic                     i_clk_pixel,
    input  logic                     i_reset,
    input  logic                     i_chunk_valid,
    input  fb_pkg::chunk_u           i_chunk,
    input  logic                     i_chunk_last,
    output logic                     o_chunk_ready,
    output logic                     o_pixel_valid,
    output logic [fb_pkg::PIX_W-1:0] o_pixel,
    output logic                     o_pixel_last,
    input  logic                     i_pixel_ready
);
    fb_pkg::chunk_u held;           // chunk being played out
    logic           held_last;      // held chunk closes the frame
    logic [2:0]     pix_idx;        // pixel currently on the output
    logic           spent;          // last pixel of held chunk leaves this cycle
    logic           take;

    assign spent         = i_pixel_ready && &pix_idx;
    assign o_chunk_ready = !o_pixel_valid || spent;
    assign take          = i_chunk_valid && o_chunk_ready;
    assign o_pixel       = held.pix[pix_idx];          // low pixel first
    assign o_pixel_last  = held_last && &pix_idx;

    always_ff @(posedge i_clk_pixel) begin
        if (take) begin
            held      <= i_chunk;
            held_last <= i_chunk_last;
        end
    end

    always_ff @(posedge i_clk_pixel) begin
        if (i_reset) begin
            o_pixel_valid <= 1'b0;
            pix_idx       <= '0;
        end else if (take) begin
            o_pixel_valid <= 1'b1;
            pix_idx       <= '0;
        end else if (o_pixel_valid && i_pixel_ready) begin
            pix_idx <= pix_idx + 1'b1;
            if (&pix_idx) begin
                o_pixel_valid <= 1'b0;                  // ran dry, no chunk waiting
            end
        end
    end

endmodule
